//--- uno_table.f
hw/uno_pkg.sv
hw/uno_regs_pkg.sv
hw/uno_hand_counter.sv
hw/uno_apb_regs.sv
hw/uno_turn_fsm.sv
hw/uno_table.sv
testbench/uno_table_tb.sv

//--- Makefile
TOP       ?= uno_table_tb
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -j 0

FILELIST  := uno_table.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/uno_table_tb.sv
module uno_table_tb import uno_pkg::*, uno_regs_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RST_CYCLES        = 10;
    localparam int RANDOM_MAX        = 300;
    localparam int SCRIPTED_ACTIONS  = 20;
    localparam int CYCLES_PER_ACTION = 16;   // one action plus two register reads

    logic      clk;
    logic      rst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      play;
    logic      draw;
    card_t     card_in;
    logic      ready;
    logic      finished;
    seat_t     seat;
    card_t     last_card;

    int        m_cnt [NUM_SEATS];          // reference model of the table
    seat_t     m_seat     = '0;
    logic      m_dir      = 1'b0;
    card_t     m_last     = '0;
    logic      m_finished = 1'b0;
    logic      m_illegal  = 1'b0;
    card_t     m_top      = '0;
    int        m_deal     = 7;
    int        seed;
    int        r;
    string     test_name;
    apb_data_t rd_data;
    logic      rd_err;

    uno_table uut (
        .i_clk(clk),
        .i_rst_n(rst_n),
        .i_psel(psel),
        .i_penable(penable),
        .i_pwrite(pwrite),
        .i_paddr(paddr),
        .i_pwdata(pwdata),
        .o_prdata(prdata),
        .o_pready(pready),
        .o_pslverr(pslverr),
        .i_play(play),
        .i_draw(draw),
        .i_card(card_in),
        .o_ready(ready),
        .o_finished(finished),
        .o_seat(seat),
        .o_last_card(last_card)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("ERROR in %s: %s", test_name, why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    function automatic int add_cards(input int cnt, input int num);
        return (cnt + num > 127) ? 127 : cnt + num;   // hands saturate
    endfunction

    // next table state from the game rules
    function automatic void model_step(input logic is_play, input card_t card);
        seat_t step;
        seat_t victim;
        rank_t rank;
        rank = card[3:0];
        step = m_dir ? 2'd3 : 2'd1;
        if (!is_play) begin
            m_cnt[m_seat] = add_cards(m_cnt[m_seat], 1);
            m_seat = m_seat + step;
            return;
        end
        if (rank != RANK_WILD && rank != RANK_WILD4 && card[5:4] != m_last[5:4] &&
            rank != m_last[3:0]) begin
            m_illegal = 1'b1;
            return;
        end
        m_last = card;
        m_cnt[m_seat] = m_cnt[m_seat] - 1;
        if (m_cnt[m_seat] == 0) begin
            m_finished = 1'b1;                  // last card, no penalty
            return;
        end
        case (rank)
            RANK_SKIP: m_seat = m_seat + step + step;
            RANK_REVERSE: begin
                m_dir  = !m_dir;
                m_seat = m_dir ? m_seat - 2'd1 : m_seat + 2'd1;
            end
            RANK_DRAW2, RANK_WILD4: begin
                victim = m_seat + step;
                m_cnt[victim] = add_cards(m_cnt[victim], (rank == RANK_DRAW2) ? 2 : 4);
                m_seat = victim + step;
            end
            default: m_seat = m_seat + step;
        endcase
    endfunction

    function automatic card_t pick_legal_card(input card_t last, input int rnd);
        logic [1:0] colour;
        logic [3:0] rank;
        colour = rnd[5:4];
        rank   = 4'($unsigned(rnd >> 8) % 15);
        case (rnd[1:0])
            2'd1: return {colour, last[3:0]};
            2'd2: return {colour, (rnd[6] ? RANK_WILD4 : RANK_WILD)};
            default: return {last[5:4], rank};
        endcase
    endfunction

    // model follows the bus and the accepted actions, then compares
    always begin
        @(negedge clk);
        if (rst_n && psel && penable && pwrite) begin
            if (paddr == ADDR_TOP_CARD) begin
                m_top = pwdata[5:0];
            end
            if (paddr == ADDR_CTRL) begin
                m_deal = 32'(pwdata[14:8]);
                if (pwdata[0]) begin
                    for (int s = 0; s < NUM_SEATS; s++) begin
                        m_cnt[s] = m_deal;
                    end
                    m_seat     = '0;
                    m_dir      = 1'b0;
                    m_last     = m_top;
                    m_finished = 1'b0;
                    m_illegal  = 1'b0;
                end
            end
        end
        if (rst_n && ready && (play || draw)) begin
            model_step(play, card_in);
            @(negedge clk);
            check_value("seat", 32'(m_seat), 32'(seat));
            check_value("last card", 32'(m_last), 32'(last_card));
            check_value("finished", 32'(m_finished), 32'(finished));
            check_value("ready", 32'(!m_finished), 32'(ready));
        end
    end

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        check_value("pready", 32'd1, 32'(pready));
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_regs();
        apb_data_t data;
        apb_data_t expected;
        logic      err;
        apb_read(ADDR_HANDS, data, err);
        expected = '0;
        for (int s = 0; s < NUM_SEATS; s++) begin
            expected[s*HAND_LANE_W +: HAND_LANE_W] = 8'(m_cnt[s]);
        end
        check_value("hands", expected, data);
        check_value("hands pslverr", 32'd0, 32'(err));
        apb_read(ADDR_STATUS, data, err);
        expected = '0;
        expected[STAT_FINISHED_BIT]   = m_finished;
        expected[STAT_DIR_BIT]        = m_dir;
        expected[STAT_SEAT_LSB +: 2]  = m_seat;
        expected[STAT_ILLEGAL_BIT]    = m_illegal;
        check_value("status", expected, data);
    endtask

    task automatic wait_ready(input int max_cycles);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!ready) begin
            if (waited >= max_cycles) begin
                abort_run("o_ready did not rise in time");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic start_game(input hand_cnt_t deal, input card_t top);
        apb_write(ADDR_TOP_CARD, 32'(top));
        apb_write(ADDR_CTRL, 32'({deal, 8'h00}));
        apb_write(ADDR_CTRL, 32'({deal, 8'h01}));   // start
        wait_ready(10);
    endtask

    task automatic take_action(input logic do_play, input logic do_draw, input card_t card);
        wait_ready(8);
        @(posedge clk);
        #1;
        play    = do_play;
        draw    = do_draw;
        card_in = card;
        @(posedge clk);
        #1;
        play = 1'b0;
        draw = 1'b0;
        check_regs();
    endtask

    initial begin
        repeat (RST_CYCLES + (SCRIPTED_ACTIONS + RANDOM_MAX) * CYCLES_PER_ACTION) @(posedge clk);
        abort_run("watchdog expired before the tests completed");
    end

    initial begin
        seed    = 56114;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        play    = 1'b0;
        draw    = 1'b0;
        card_in = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_name = "reset_setup";
        check_value("ready", 32'd0, 32'(ready));
        check_value("finished", 32'd0, 32'(finished));
        check_regs();
        start_game(7'd5, {2'd1, 4'd3});
        check_value("seat", 32'd0, 32'(seat));
        check_value("last card", 32'({2'd1, 4'd3}), 32'(last_card));
        check_regs();

        test_name = "rotation";
        start_game(7'd7, {2'd1, 4'd3});
        take_action(1'b1, 1'b0, {2'd1, 4'd5});
        take_action(1'b1, 1'b0, {2'd2, 4'd5});
        take_action(1'b1, 1'b0, {2'd2, RANK_SKIP});
        take_action(1'b1, 1'b0, {2'd2, RANK_REVERSE});
        take_action(1'b1, 1'b0, {2'd0, RANK_REVERSE});
        take_action(1'b1, 1'b0, {2'd0, RANK_SKIP});
        take_action(1'b1, 1'b0, {2'd0, RANK_REVERSE});
        take_action(1'b1, 1'b0, {2'd0, 4'd7});

        test_name = "penalties";
        take_action(1'b0, 1'b1, 6'd0);
        take_action(1'b1, 1'b0, {2'd0, RANK_DRAW2});
        take_action(1'b1, 1'b0, {2'd3, RANK_WILD4});
        take_action(1'b0, 1'b1, 6'd0);
        take_action(1'b1, 1'b0, {2'd3, 4'd2});

        test_name = "illegal";
        take_action(1'b1, 1'b0, {2'd1, 4'd8});
        take_action(1'b1, 1'b1, {2'd3, 4'd9});   // play beats draw
        apb_read(8'h10, rd_data, rd_err);
        check_value("unmapped pslverr", 32'd1, 32'(rd_err));

        test_name = "random_game";
        start_game(7'd2, {2'd0, 4'd4});
        for (int n = 0; n < RANDOM_MAX && !m_finished; n++) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                take_action(1'b0, 1'b1, 6'd0);
            end
            else begin
                take_action(1'b1, r[3], pick_legal_card(m_last, r));
            end
        end
        check_value("finished", 32'd1, 32'(finished));
        check_value("ready", 32'd0, 32'(ready));
        apb_read(ADDR_HANDS, rd_data, rd_err);
        check_value("winner count", 32'd0, 32'(rd_data[m_seat*HAND_LANE_W +: HAND_LANE_W]));

        $display("TEST OK");
        $finish;
    end

endmodule

//--- hw/uno_table.sv
module uno_table import uno_pkg::*, uno_regs_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_psel,
    input  logic      i_penable,
    input  logic      i_pwrite,
    input  apb_addr_t i_paddr,
    input  apb_data_t i_pwdata,
    output apb_data_t o_prdata,
    output logic      o_pready,
    output logic      o_pslverr,
    input  logic      i_play,
    input  logic      i_draw,
    input  card_t     i_card,
    output logic      o_ready,
    output logic      o_finished,
    output seat_t     o_seat,
    output card_t     o_last_card
);

    logic       start_pulse;
    hand_cnt_t  deal_size;
    card_t      top_card;
    logic       deal;
    logic       add_en;
    seat_t      add_seat;
    logic [2:0] add_num;
    logic       dec_en;
    seat_t      dec_seat;
    logic       dir;
    logic       illegal;
    hand_cnt_t  hand_cnt [NUM_SEATS];

    uno_apb_regs apb_regs (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_psel(i_psel),
        .i_penable(i_penable),
        .i_pwrite(i_pwrite),
        .i_paddr(i_paddr),
        .i_pwdata(i_pwdata),
        .o_prdata(o_prdata),
        .o_pready(o_pready),
        .o_pslverr(o_pslverr),
        .i_seat(o_seat),
        .i_dir(dir),
        .i_finished(o_finished),
        .i_illegal(illegal),
        .i_hand_cnt(hand_cnt),
        .o_start(start_pulse),
        .o_deal_size(deal_size),
        .o_top_card(top_card)
    );

    uno_turn_fsm turn_fsm (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_start(start_pulse),
        .i_top_card(top_card),
        .i_play(i_play),
        .i_draw(i_draw),
        .i_card(i_card),
        .i_hand_cnt(hand_cnt),
        .o_ready(o_ready),
        .o_deal(deal),
        .o_add_en(add_en),
        .o_add_seat(add_seat),
        .o_add_num(add_num),
        .o_dec_en(dec_en),
        .o_dec_seat(dec_seat),
        .o_seat(o_seat),
        .o_dir(dir),
        .o_last_card(o_last_card),
        .o_finished(o_finished),
        .o_illegal(illegal)
    );

    uno_hand_counter hand_counter (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_deal(deal),
        .i_deal_size(deal_size),
        .i_add_en(add_en),
        .i_add_seat(add_seat),
        .i_add_num(add_num),
        .i_dec_en(dec_en),
        .i_dec_seat(dec_seat),
        .o_hand_cnt(hand_cnt)
    );

endmodule

//--- hw/uno_turn_fsm.sv
module uno_turn_fsm import uno_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  card_t      i_top_card,
    input  logic       i_play,
    input  logic       i_draw,
    input  card_t      i_card,
    input  hand_cnt_t  i_hand_cnt [NUM_SEATS],
    output logic       o_ready,
    output logic       o_deal,
    output logic       o_add_en,
    output seat_t      o_add_seat,
    output logic [2:0] o_add_num,
    output logic       o_dec_en,
    output seat_t      o_dec_seat,
    output seat_t      o_seat,
    output logic       o_dir,
    output card_t      o_last_card,
    output logic       o_finished,
    output logic       o_illegal
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_DEAL,
        S_TURN,
        S_END
    } state_t;

    state_t state_w, state_r;
    seat_t  seat_w, seat_r;
    logic   dir_w, dir_r;          // 0 clockwise, 1 reversed
    card_t  last_card_w, last_card_r;

    rank_t  play_rank;
    logic   legal;
    logic   do_play;
    logic   do_draw;
    logic   win;
    seat_t  next_seat;
    seat_t  skip_seat;
    seat_t  back_seat;

    assign o_ready     = (state_r == S_TURN);
    assign o_deal      = (state_r == S_DEAL);
    assign o_finished  = (state_r == S_END);
    assign o_seat      = seat_r;
    assign o_dir       = dir_r;
    assign o_last_card = last_card_r;

    assign play_rank = card_rank(i_card);
    assign legal     = is_wild(i_card) ||
                       (card_colour(i_card) == card_colour(last_card_r)) ||
                       (play_rank == card_rank(last_card_r));
    assign do_play   = o_ready && i_play;
    assign do_draw   = o_ready && i_draw && !i_play;   // play wins a tie
    assign win       = (i_hand_cnt[seat_r] == hand_cnt_t'(1));

    assign next_seat = dir_r ? seat_r - 2'd1 : seat_r + 2'd1;
    assign skip_seat = seat_r + 2'd2;                  // same seat either way round
    assign back_seat = dir_r ? seat_r + 2'd1 : seat_r - 2'd1;

    always_comb begin
        state_w     = state_r;
        seat_w      = seat_r;
        dir_w       = dir_r;
        last_card_w = last_card_r;
        o_add_en    = 1'b0;
        o_add_seat  = seat_r;
        o_add_num   = 3'd0;
        o_dec_en    = 1'b0;
        o_dec_seat  = seat_r;
        o_illegal   = 1'b0;
        case (state_r)
            S_DEAL: begin
                state_w     = S_TURN;
                seat_w      = '0;
                dir_w       = 1'b0;
                last_card_w = i_top_card;
            end
            S_TURN: begin
                if (do_play && !legal) begin
                    o_illegal = 1'b1;      // dropped, same seat again
                end
                else if (do_play) begin
                    last_card_w = i_card;
                    o_dec_en    = 1'b1;
                    if (win) begin
                        state_w = S_END;   // no penalty on the last card
                    end
                    else begin
                        case (play_rank)
                            RANK_SKIP: seat_w = skip_seat;
                            RANK_REVERSE: begin
                                dir_w  = ~dir_r;
                                seat_w = back_seat;
                            end
                            RANK_DRAW2, RANK_WILD4: begin
                                o_add_en   = 1'b1;
                                o_add_seat = next_seat;
                                o_add_num  = (play_rank == RANK_DRAW2) ? PEN_DRAW2 : PEN_WILD4;
                                seat_w     = skip_seat;   // victim loses the turn
                            end
                            default: seat_w = next_seat;
                        endcase
                    end
                end
                else if (do_draw) begin
                    o_add_en  = 1'b1;
                    o_add_num = PEN_DRAW;
                    seat_w    = next_seat;
                end
            end
            default: ;
        endcase
        if (i_start) begin
            state_w = S_DEAL;              // restart from any state
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r     <= S_IDLE;
            seat_r      <= '0;
            dir_r       <= 1'b0;
            last_card_r <= '0;
        end
        else begin
            state_r     <= state_w;
            seat_r      <= seat_w;
            dir_r       <= dir_w;
            last_card_r <= last_card_w;
        end
    end

    // seat on turn always holds a card
    a_turn_holds_card: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_ready |-> (i_hand_cnt[seat_r] != '0));

    // game ends with the winner's hand empty
    a_win_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_finished) |-> (i_hand_cnt[seat_r] == '0));

endmodule

//--- hw/uno_apb_regs.sv
module uno_apb_regs import uno_pkg::*, uno_regs_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_psel,
    input  logic      i_penable,
    input  logic      i_pwrite,
    input  apb_addr_t i_paddr,
    input  apb_data_t i_pwdata,
    output apb_data_t o_prdata,
    output logic      o_pready,
    output logic      o_pslverr,
    input  seat_t     i_seat,
    input  logic      i_dir,
    input  logic      i_finished,
    input  logic      i_illegal,
    input  hand_cnt_t i_hand_cnt [NUM_SEATS],
    output logic      o_start,
    output hand_cnt_t o_deal_size,
    output card_t     o_top_card
);

    logic      start_r;
    hand_cnt_t deal_size_r;
    card_t     top_card_r;
    logic      illegal_r;

    logic      access;
    logic      mapped;
    logic      wr_ctrl;
    logic      wr_top;
    logic      start_wr;

    assign access = i_psel && i_penable;
    assign mapped = (i_paddr == ADDR_CTRL) || (i_paddr == ADDR_TOP_CARD) ||
                    (i_paddr == ADDR_STATUS) || (i_paddr == ADDR_HANDS);

    assign o_pready  = access;                 // no wait states
    assign o_pslverr = access && !mapped;

    assign wr_ctrl  = access && i_pwrite && (i_paddr == ADDR_CTRL);
    assign wr_top   = access && i_pwrite && (i_paddr == ADDR_TOP_CARD);
    assign start_wr = wr_ctrl && i_pwdata[CTRL_START_BIT];

    assign o_start     = start_r;
    assign o_deal_size = deal_size_r;
    assign o_top_card  = top_card_r;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            start_r     <= 1'b0;
            deal_size_r <= DEAL_DEFAULT;
            top_card_r  <= '0;
            illegal_r   <= 1'b0;
        end
        else begin
            start_r <= start_wr;               // one cycle pulse
            if (wr_ctrl) begin
                deal_size_r <= i_pwdata[CTRL_DEAL_LSB +: HAND_W];
            end
            if (wr_top) begin
                top_card_r <= i_pwdata[CARD_W-1:0];
            end
            if (start_wr) begin
                illegal_r <= 1'b0;             // new game, clean flag
            end
            else if (i_illegal) begin
                illegal_r <= 1'b1;
            end
        end
    end

    always_comb begin
        o_prdata = '0;
        case (i_paddr)
            ADDR_CTRL: begin
                o_prdata[CTRL_DEAL_LSB +: HAND_W] = deal_size_r;
            end
            ADDR_TOP_CARD: begin
                o_prdata[CARD_W-1:0] = top_card_r;
            end
            ADDR_STATUS: begin
                o_prdata[STAT_FINISHED_BIT]   = i_finished;
                o_prdata[STAT_DIR_BIT]        = i_dir;
                o_prdata[STAT_SEAT_LSB +: 2]  = i_seat;
                o_prdata[STAT_ILLEGAL_BIT]    = illegal_r;
            end
            ADDR_HANDS: begin
                for (int s = 0; s < NUM_SEATS; s++) begin
                    o_prdata[s*HAND_LANE_W +: HAND_W] = i_hand_cnt[s];  // top bit of lane stays 0
                end
            end
            default: ;
        endcase
    end

    // access phase must follow a setup phase on the same select
    a_penable_psel: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_penable |-> i_psel);

endmodule

//--- hw/uno_hand_counter.sv
module uno_hand_counter import uno_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_deal,
    input  hand_cnt_t  i_deal_size,
    input  logic       i_add_en,
    input  seat_t      i_add_seat,
    input  logic [2:0] i_add_num,
    input  logic       i_dec_en,
    input  seat_t      i_dec_seat,
    output hand_cnt_t  o_hand_cnt [NUM_SEATS]
);

    hand_cnt_t cnt_r [NUM_SEATS];

    function automatic hand_cnt_t sat_add(hand_cnt_t cnt, logic [2:0] num);
        logic [HAND_W:0] sum;
        sum = {1'b0, cnt} + {{(HAND_W-2){1'b0}}, num};
        return sum[HAND_W] ? HAND_MAX : sum[HAND_W-1:0];
    endfunction

    assign o_hand_cnt = cnt_r;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int s = 0; s < NUM_SEATS; s++) begin
                cnt_r[s] <= '0;
            end
        end
        else if (i_deal) begin
            for (int s = 0; s < NUM_SEATS; s++) begin
                cnt_r[s] <= i_deal_size;   // every hand gets the deal
            end
        end
        else begin
            for (int s = 0; s < NUM_SEATS; s++) begin
                if (i_add_en && (i_add_seat == seat_t'(s))) begin
                    cnt_r[s] <= sat_add(cnt_r[s], i_add_num);
                end
                else if (i_dec_en && (i_dec_seat == seat_t'(s))) begin
                    cnt_r[s] <= cnt_r[s] - hand_cnt_t'(1);
                end
            end
        end
    end

    // turn logic only lets a seat play a card it holds
    a_dec_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_dec_en && !i_deal) |-> (cnt_r[i_dec_seat] != '0));

endmodule

//--- hw/uno_regs_pkg.sv
package uno_regs_pkg;

    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    // register offsets
    localparam apb_addr_t ADDR_CTRL     = 8'h00;
    localparam apb_addr_t ADDR_TOP_CARD = 8'h04;
    localparam apb_addr_t ADDR_STATUS   = 8'h08;   // read only
    localparam apb_addr_t ADDR_HANDS    = 8'h0C;   // read only

    // CTRL fields
    localparam int CTRL_START_BIT = 0;     // write one to pulse
    localparam int CTRL_DEAL_LSB  = 8;     // deal size in 14..8

    // STATUS fields
    localparam int STAT_FINISHED_BIT = 0;
    localparam int STAT_DIR_BIT      = 1;
    localparam int STAT_SEAT_LSB     = 4;
    localparam int STAT_ILLEGAL_BIT  = 8;  // sticky until next start

    // HANDS holds one byte lane per seat
    localparam int HAND_LANE_W = 8;

endpackage

//--- hw/uno_pkg.sv
package uno_pkg;

    localparam int CARD_W    = 6;
    localparam int HAND_W    = 7;
    localparam int NUM_SEATS = 4;

    typedef logic [CARD_W-1:0] card_t;     // {colour, rank}
    typedef logic [3:0]        rank_t;
    typedef logic [1:0]        colour_t;   // chosen colour on a wild
    typedef logic [1:0]        seat_t;
    typedef logic [HAND_W-1:0] hand_cnt_t;

    // ranks 0..9 are number cards
    localparam rank_t RANK_SKIP    = 4'd10;
    localparam rank_t RANK_REVERSE = 4'd11;
    localparam rank_t RANK_DRAW2   = 4'd12;
    localparam rank_t RANK_WILD    = 4'd13;
    localparam rank_t RANK_WILD4   = 4'd14;

    localparam hand_cnt_t DEAL_DEFAULT = 7'd7;
    localparam hand_cnt_t HAND_MAX     = '1;   // counts saturate here

    localparam logic [2:0] PEN_DRAW  = 3'd1;   // plain draw
    localparam logic [2:0] PEN_DRAW2 = 3'd2;
    localparam logic [2:0] PEN_WILD4 = 3'd4;

    function automatic colour_t card_colour(card_t card);
        return card[5:4];
    endfunction

    function automatic rank_t card_rank(card_t card);
        return card[3:0];
    endfunction

    function automatic logic is_wild(card_t card);
        rank_t rank;
        rank = card[3:0];
        return (rank == RANK_WILD) || (rank == RANK_WILD4);
    endfunction

endpackage
